// File: Bender.yml
package:
  name: ltpi_mgmt_tx

sources:
  - logic/ltpi_tx_pkg.sv
  - logic/ltpi_frame_builder.sv
  - logic/ltpi_frame_counters.sv
  - logic/ltpi_speed_negotiator.sv
  - logic/ltpi_mgmt_tx.sv
  - target: simulation
    files:
      - dv/ltpi_mgmt_tx_tb.sv

// File: dv/ltpi_mgmt_tx_tb.sv
// Directed testbench for the LTPI transmit manager, run with the project file list
`timescale 1ns/1ps
`default_nettype none

module ltpi_mgmt_tx_tb import ltpi_tx_pkg::*; ();

    localparam int CLK_PERIOD      = 100;
    localparam int EST_TEST_CYCLES = 6500;
    localparam int WATCHDOG_CYCLES = 3 * EST_TEST_CYCLES + 500;

    logic         clk;
    logic         reset;
    link_st_t     link_st;
    logic         change_freq_st;
    frm_offset_t  tx_frm_offset;
    speed_capab_t local_speed_capab;
    speed_capab_t remote_speed_capab;
    logic [15:0]  platform_id;
    capab_bytes_t advertise_capab;
    capab_bytes_t config_capab;
    frame_t       operational_frame;
    frame_t       tx_frame;
    logic         detect_frames_sent;
    logic         speed_frames_sent;
    logic         cfg_timeout;
    logic [15:0]  detect_count;
    logic [7:0]   speed_count;
    logic [7:0]   cfg_count;
    logic [31:0]  advertise_count;
    logic [31:0]  operational_count;
    link_speed_t  link_speed;
    logic         lvds_ddr;

    logic [31:0]  rng_state;
    logic         failed;

    ltpi_mgmt_tx UUT (
        .clk                (clk),
        .reset              (reset),
        .link_st            (link_st),
        .change_freq_st     (change_freq_st),
        .tx_frm_offset      (tx_frm_offset),
        .local_speed_capab  (local_speed_capab),
        .remote_speed_capab (remote_speed_capab),
        .platform_id        (platform_id),
        .advertise_capab    (advertise_capab),
        .config_capab       (config_capab),
        .operational_frame  (operational_frame),
        .tx_frame           (tx_frame),
        .detect_frames_sent (detect_frames_sent),
        .speed_frames_sent  (speed_frames_sent),
        .cfg_timeout        (cfg_timeout),
        .detect_count       (detect_count),
        .speed_count        (speed_count),
        .cfg_count          (cfg_count),
        .advertise_count    (advertise_count),
        .operational_count  (operational_count),
        .link_speed         (link_speed),
        .lvds_ddr           (lvds_ddr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    // --------------------
    // Random numbers
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic logic [15:0] rand16();
        logic [31:0] r;
        r = next_rand();
        return r[15:0];
    endfunction

    function automatic logic [7:0] rand8();
        logic [31:0] r;
        r = next_rand();
        return r[7:0];
    endfunction

    // --------------------
    // Expected frames and speed
    function automatic frame_t detect_speed_layout(input logic [7:0] sub, input speed_capab_t mask);
        frame_t f;
        f = '0;
        f[0] = K28_5;
        f[1] = sub;
        f[2] = LTPI_VERSION;
        f[3] = mask[7:0];
        f[4] = mask[15:8];
        return f;
    endfunction

    function automatic frame_t advertise_layout(input logic [15:0] pid, input capab_bytes_t cap);
        frame_t f;
        f = '0;
        f[0] = K28_6;
        f[1] = SUB_ADVERTISE;
        f[2] = pid[15:8];
        f[3] = pid[7:0];
        f[4] = CAPAB_TYPE_DEFAULT;
        for (int i = 0; i < 8; i++) f[5 + i] = cap[i];
        return f;
    endfunction

    function automatic frame_t configure_layout(input capab_bytes_t cap);
        frame_t f;
        f = '0;
        f[0] = K28_6;
        f[1] = SUB_CONFIGURE;
        f[2] = CAPAB_TYPE_DEFAULT;
        for (int i = 0; i < 8; i++) f[3 + i] = cap[i];
        return f;
    endfunction

    // Scan from the top bit down, first hit is the fastest common speed
    function automatic link_speed_t highest_common_speed(input speed_capab_t common);
        link_speed_t spd;
        logic        found;
        spd = SPD_X1;
        found = 1'b0;
        for (int b = 11; b >= 0; b--) begin
            if (!found && common[b]) begin
                spd = link_speed_t'(b);
                found = 1'b1;
            end
        end
        return spd;
    endfunction

    // --------------------
    // Compare tasks
    task automatic stop_on_mismatch();
        failed = 1'b1;
        $display("Simulation failed");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic check_frame(input string name, input frame_t exp, input frame_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            stop_on_mismatch();
        end
    endtask

    task automatic check_count(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            stop_on_mismatch();
        end
    endtask

    task automatic check_speed(input string name, input link_speed_t exp, input link_speed_t act);
        if (act !== exp) begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            stop_on_mismatch();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            stop_on_mismatch();
        end
    endtask

    // --------------------
    // Stimulus
    task automatic set_state(input link_st_t st);
        @(negedge clk);
        link_st       = st;
        tx_frm_offset = '0;
    endtask

    // Offsets 0..15, then 15 held two more cycles so the count has landed
    task automatic send_frame();
        for (int k = 0; k < 16; k++) begin
            @(negedge clk);
            tx_frm_offset = frm_offset_t'(k);
        end
        repeat (2) @(negedge clk);
    endtask

    // --------------------
    // Tests
    task automatic test_detect_frame();
        local_speed_capab = rand16();
        set_state(ST_COMMA_HUNTING);
        send_frame();
        check_frame("detect_layout", detect_speed_layout(SUB_DETECT, local_speed_capab), tx_frame);
        check_count("detect_hunting_count", 32'd0, detect_count);
        set_state(ST_WAIT_LINK_DETECT_LOCKED);
        for (int n = 1; n <= 255; n++) begin
            send_frame();
            if (n == 254) check_flag("detect_sent_early", 1'b0, detect_frames_sent);
        end
        check_count("detect_count", 32'd255, detect_count);
        @(negedge clk);
        check_flag("detect_sent", 1'b1, detect_frames_sent);
    endtask

    task automatic negotiate_pair(input speed_capab_t loc, input speed_capab_t rem);
        speed_capab_t common;
        common = loc & rem;
        set_state(ST_INIT);
        local_speed_capab  = loc;
        remote_speed_capab = rem;
        set_state(ST_WAIT_LINK_DETECT_LOCKED);
        set_state(ST_WAIT_LINK_SPEED_LOCKED);
        @(negedge clk);
        check_speed("speed_gated", SPD_X1, link_speed);
        check_flag("ddr_gated", 1'b0, lvds_ddr);
        set_state(ST_WAIT_LINK_ADVERTISE_LOCKED);
        @(negedge clk);
        check_speed("speed_negotiated", highest_common_speed(common), link_speed);
        check_flag("ddr_negotiated", common[DDR_BIT], lvds_ddr);
    endtask

    task automatic test_speed_negotiation();
        negotiate_pair(16'h8000, 16'h8000);
        for (int n = 0; n < 8; n++) begin
            negotiate_pair(rand16(), rand16() & rand16());
        end
    endtask

    task automatic test_speed_frames();
        set_state(ST_INIT);
        local_speed_capab  = rand16();
        remote_speed_capab = rand16();
        set_state(ST_WAIT_LINK_SPEED_LOCKED);
        for (int n = 1; n <= 7; n++) begin
            send_frame();
            check_frame("speed_layout",
                        detect_speed_layout(SUB_SPEED, local_speed_capab & remote_speed_capab),
                        tx_frame);
            check_count("speed_count", n, speed_count);
            if (n == 6) check_flag("speed_sent_early", 1'b0, speed_frames_sent);
        end
        @(negedge clk);
        check_flag("speed_sent", 1'b1, speed_frames_sent);
        set_state(ST_INIT);
        @(negedge clk);
        check_flag("speed_sent_init", 1'b0, speed_frames_sent);
    endtask

    task automatic test_advertise_configure();
        platform_id = rand16();
        for (int k = 0; k < 8; k++) advertise_capab[k] = rand8();
        for (int k = 0; k < 8; k++) config_capab[k] = rand8();
        set_state(ST_WAIT_IN_ADVERTISE);
        for (int n = 1; n <= 3; n++) begin
            send_frame();
            check_frame("advertise_layout", advertise_layout(platform_id, advertise_capab),
                        tx_frame);
            check_count("advertise_count", n, advertise_count);
        end
        set_state(ST_CONFIGURATION_OR_ACCEPT);
        for (int n = 1; n <= 32; n++) begin
            send_frame();
            check_frame("configure_layout", configure_layout(config_capab), tx_frame);
            check_count("cfg_count", n, cfg_count);
            if (n == 31) check_flag("cfg_timeout_early", 1'b0, cfg_timeout);
        end
        @(negedge clk);
        check_flag("cfg_timeout", 1'b1, cfg_timeout);
    endtask

    task automatic test_operational_clear();
        // Leave every count and the negotiated speed away from their cleared values
        local_speed_capab  = 16'h0fff;
        remote_speed_capab = 16'h0f0f;
        set_state(ST_WAIT_LINK_DETECT_LOCKED);
        send_frame();
        check_count("detect_before_clear", 32'd1, detect_count);
        set_state(ST_WAIT_LINK_SPEED_LOCKED);
        send_frame();
        check_count("speed_before_clear", 32'd1, speed_count);
        set_state(ST_OPERATIONAL);
        for (int n = 1; n <= 2; n++) begin
            for (int k = 0; k < 16; k++) operational_frame[k] = rand8();
            send_frame();
            check_frame("operational_copy", operational_frame, tx_frame);
            check_count("operational_count", n, operational_count);
        end
        check_speed("operational_speed",
                    highest_common_speed(local_speed_capab & remote_speed_capab), link_speed);
        change_freq_st = 1'b0;
        set_state(ST_INIT);
        @(negedge clk);
        check_count("clear_detect", 32'd0, detect_count);
        check_count("clear_speed", 32'd0, speed_count);
        check_count("clear_cfg", 32'd0, cfg_count);
        check_count("clear_advertise", 32'd0, advertise_count);
        check_count("clear_operational", 32'd0, operational_count);
        check_frame("clear_frame", '0, tx_frame);
        // Status is ungated here, so it shows the register left by the clear
        set_state(ST_WAIT_LINK_ADVERTISE_LOCKED);
        @(negedge clk);
        check_speed("clear_speed_status", SPD_X1, link_speed);
    endtask

    initial begin
        rng_state          = 32'h88ee_50b4;
        failed             = 1'b0;
        reset              = 1'b1;
        link_st            = ST_INIT;
        change_freq_st     = 1'b0;
        tx_frm_offset      = '0;
        local_speed_capab  = '0;
        remote_speed_capab = '0;
        platform_id        = '0;
        advertise_capab    = '0;
        config_capab       = '0;
        operational_frame  = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        test_detect_frame();
        test_speed_negotiation();
        test_speed_frames();
        test_advertise_configure();
        test_operational_clear();

        if (!failed) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/ltpi_frame_builder.sv
// Builds the LTPI transmit frame one byte per cycle at the serializer offset, flags frame ends
`timescale 1ns/1ps
`default_nettype none

module ltpi_frame_builder import ltpi_tx_pkg::*; (
    input  wire                clk,
    input  wire                reset,
    input  wire link_st_t      link_st,
    input  wire                change_freq_st,
    input  wire frm_offset_t   tx_frm_offset,
    input  wire speed_capab_t  local_speed_capab,
    input  wire speed_capab_t  speed_select,
    input  wire [15:0]         platform_id,
    input  wire capab_bytes_t  advertise_capab,
    input  wire capab_bytes_t  config_capab,
    input  wire frame_t        operational_frame,
    output frame_t             tx_frame,
    output frame_kind_t        frame_kind,
    output logic               frame_done
);

    frame_kind_t  cur_kind;
    speed_capab_t frame_mask;
    logic [7:0]   byte_val;
    logic [2:0]   adv_idx;
    logic [2:0]   cfg_idx;
    logic         clear_st;
    logic         done_ok;
    logic         once_flag;

    assign clear_st   = (link_st == ST_INIT) || (link_st == ST_LINK_LOST_ERR);
    assign frame_mask = (cur_kind == FRM_SPEED) ? speed_select : local_speed_capab;
    assign adv_idx    = 3'(tx_frm_offset - 4'd5);
    assign cfg_idx    = 3'(tx_frm_offset - 4'd3);

    // Detect frames while hunting for comma are not counted
    assign done_ok = (tx_frm_offset == LAST_OFFSET) && (cur_kind != FRM_IDLE) &&
                     !(cur_kind == FRM_DETECT && link_st == ST_COMMA_HUNTING);

    always_comb begin
        cur_kind = FRM_IDLE;
        case (link_st)
            ST_COMMA_HUNTING:
                cur_kind = change_freq_st ? FRM_ADVERTISE : FRM_DETECT;
            ST_WAIT_LINK_DETECT_LOCKED:
                cur_kind = change_freq_st ? FRM_IDLE : FRM_DETECT;
            ST_WAIT_LINK_SPEED_LOCKED, ST_LINK_SPEED_CHANGE:
                cur_kind = FRM_SPEED;
            ST_WAIT_LINK_ADVERTISE_LOCKED, ST_WAIT_IN_ADVERTISE:
                cur_kind = FRM_ADVERTISE;
            ST_CONFIGURATION_OR_ACCEPT:
                cur_kind = FRM_CONFIGURE;
            ST_OPERATIONAL, ST_OPERATIONAL_RESET:
                cur_kind = FRM_OPERATIONAL;
            default:
                cur_kind = FRM_IDLE;
        endcase
    end

    // --------------------
    // Byte at the current offset
    always_comb begin
        byte_val = 8'h00;
        case (cur_kind)
            FRM_DETECT, FRM_SPEED: begin
                case (tx_frm_offset)
                    4'd0: byte_val = K28_5;
                    4'd1: byte_val = (cur_kind == FRM_DETECT) ? SUB_DETECT : SUB_SPEED;
                    4'd2: byte_val = LTPI_VERSION;
                    4'd3: byte_val = frame_mask[7:0];
                    4'd4: byte_val = frame_mask[15:8];
                    default: byte_val = 8'h00;
                endcase
            end
            FRM_ADVERTISE: begin
                case (tx_frm_offset)
                    4'd0: byte_val = K28_6;
                    4'd1: byte_val = SUB_ADVERTISE;
                    4'd2: byte_val = platform_id[15:8];
                    4'd3: byte_val = platform_id[7:0];
                    4'd4: byte_val = CAPAB_TYPE_DEFAULT;
                    4'd5, 4'd6, 4'd7, 4'd8, 4'd9, 4'd10, 4'd11, 4'd12:
                        byte_val = advertise_capab[adv_idx];
                    default: byte_val = 8'h00;
                endcase
            end
            FRM_CONFIGURE: begin
                case (tx_frm_offset)
                    4'd0: byte_val = K28_6;
                    4'd1: byte_val = SUB_CONFIGURE;
                    4'd2: byte_val = CAPAB_TYPE_DEFAULT;
                    4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9, 4'd10:
                        byte_val = config_capab[cfg_idx];
                    default: byte_val = 8'h00;
                endcase
            end
            FRM_OPERATIONAL:
                byte_val = operational_frame[tx_frm_offset];
            default:
                byte_val = 8'h00;
        endcase
    end

    // --------------------
    // Frame register and end-of-frame pulse
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx_frame   <= '0;
            frame_kind <= FRM_IDLE;
            frame_done <= 1'b0;
            once_flag  <= 1'b0;
        end else begin
            frame_kind <= cur_kind;
            frame_done <= done_ok && !once_flag;

            if (clear_st && !change_freq_st) begin
                tx_frame <= '0;
            end else if (cur_kind != FRM_IDLE) begin
                tx_frame[tx_frm_offset] <= byte_val;
            end

            // Offset may sit at 15 for several cycles, count it once
            if (clear_st || tx_frm_offset != LAST_OFFSET) begin
                once_flag <= 1'b0;
            end else if (done_ok) begin
                once_flag <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/ltpi_frame_counters.sv
// Counts sent LTPI frames per kind and raises the detect, speed and configuration timeout flags
`timescale 1ns/1ps
`default_nettype none

module ltpi_frame_counters import ltpi_tx_pkg::*; (
    input  wire               clk,
    input  wire               reset,
    input  wire link_st_t     link_st,
    input  wire               change_freq_st,
    input  wire frame_kind_t  frame_kind,
    input  wire               frame_done,
    output logic [15:0]       detect_count,
    output logic [7:0]        speed_count,
    output logic [7:0]        cfg_count,
    output logic [31:0]       advertise_count,
    output logic [31:0]       operational_count,
    output logic              detect_frames_sent,
    output logic              speed_frames_sent,
    output logic              cfg_timeout
);

    logic clear_st;

    assign clear_st = (link_st == ST_INIT) || (link_st == ST_LINK_LOST_ERR);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            detect_count      <= '0;
            speed_count       <= '0;
            cfg_count         <= '0;
            advertise_count   <= '0;
            operational_count <= '0;
        end else if (clear_st) begin
            // Detect and speed counts survive a frequency change
            if (!change_freq_st) begin
                detect_count <= '0;
                speed_count  <= '0;
            end
            cfg_count         <= '0;
            advertise_count   <= '0;
            operational_count <= '0;
        end else if (frame_done) begin
            case (frame_kind)
                FRM_DETECT:      detect_count      <= detect_count + 16'd1;
                FRM_SPEED:       speed_count       <= speed_count + 8'd1;
                FRM_ADVERTISE:   advertise_count   <= advertise_count + 32'd1;
                FRM_CONFIGURE:   cfg_count         <= cfg_count + 8'd1;
                FRM_OPERATIONAL: operational_count <= operational_count + 32'd1;
                default: begin
                end
            endcase
        end
    end

    // --------------------
    // Threshold flags
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            detect_frames_sent <= 1'b0;
            speed_frames_sent  <= 1'b0;
            cfg_timeout        <= 1'b0;
        end else begin
            detect_frames_sent <= (detect_count >= DETECT_FRM_TARGET);
            cfg_timeout        <= (cfg_count >= CFG_TIMEOUT_FRAMES);
            if (clear_st) begin
                speed_frames_sent <= 1'b0;
            end else begin
                speed_frames_sent <= (speed_count >= SPEED_FRM_TARGET);
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/ltpi_mgmt_tx.sv
// LTPI transmit manager top, joins the frame builder, sent-frame counters and speed negotiator
`timescale 1ns/1ps
`default_nettype none

module ltpi_mgmt_tx import ltpi_tx_pkg::*; (
    input  wire                clk,
    input  wire                reset,
    input  wire link_st_t      link_st,
    input  wire                change_freq_st,
    input  wire frm_offset_t   tx_frm_offset,
    input  wire speed_capab_t  local_speed_capab,
    input  wire speed_capab_t  remote_speed_capab,
    input  wire [15:0]         platform_id,
    input  wire capab_bytes_t  advertise_capab,
    input  wire capab_bytes_t  config_capab,
    input  wire frame_t        operational_frame,
    output frame_t             tx_frame,
    output logic               detect_frames_sent,
    output logic               speed_frames_sent,
    output logic               cfg_timeout,
    output logic [15:0]        detect_count,
    output logic [7:0]         speed_count,
    output logic [7:0]         cfg_count,
    output logic [31:0]        advertise_count,
    output logic [31:0]        operational_count,
    output link_speed_t        link_speed,
    output logic               lvds_ddr
);

    speed_capab_t speed_select;
    frame_kind_t  frame_kind;
    logic         frame_done;

    ltpi_frame_builder u_builder (
        .clk               (clk),
        .reset             (reset),
        .link_st           (link_st),
        .change_freq_st    (change_freq_st),
        .tx_frm_offset     (tx_frm_offset),
        .local_speed_capab (local_speed_capab),
        .speed_select      (speed_select),
        .platform_id       (platform_id),
        .advertise_capab   (advertise_capab),
        .config_capab      (config_capab),
        .operational_frame (operational_frame),
        .tx_frame          (tx_frame),
        .frame_kind        (frame_kind),
        .frame_done        (frame_done)
    );

    ltpi_frame_counters u_counters (
        .clk                (clk),
        .reset              (reset),
        .link_st            (link_st),
        .change_freq_st     (change_freq_st),
        .frame_kind         (frame_kind),
        .frame_done         (frame_done),
        .detect_count       (detect_count),
        .speed_count        (speed_count),
        .cfg_count          (cfg_count),
        .advertise_count    (advertise_count),
        .operational_count  (operational_count),
        .detect_frames_sent (detect_frames_sent),
        .speed_frames_sent  (speed_frames_sent),
        .cfg_timeout        (cfg_timeout)
    );

    ltpi_speed_negotiator u_negotiator (
        .clk                (clk),
        .reset              (reset),
        .link_st            (link_st),
        .change_freq_st     (change_freq_st),
        .local_speed_capab  (local_speed_capab),
        .remote_speed_capab (remote_speed_capab),
        .speed_select       (speed_select),
        .link_speed         (link_speed),
        .lvds_ddr           (lvds_ddr)
    );

endmodule

`default_nettype wire

// File: logic/ltpi_speed_negotiator.sv
// Negotiates the common LTPI link speed and DDR mode and gates them onto the status outputs
`timescale 1ns/1ps
`default_nettype none

module ltpi_speed_negotiator import ltpi_tx_pkg::*; (
    input  wire               clk,
    input  wire               reset,
    input  wire link_st_t     link_st,
    input  wire               change_freq_st,
    input  wire speed_capab_t local_speed_capab,
    input  wire speed_capab_t remote_speed_capab,
    output speed_capab_t      speed_select,
    output link_speed_t       link_speed,
    output logic              lvds_ddr
);

    link_speed_t speed_reg;
    link_speed_t top_speed;
    logic        top_valid;
    logic        ddr_reg;
    logic        update_st;
    logic        reset_st;
    logic        status_en;

    assign speed_select = local_speed_capab & remote_speed_capab;

    assign update_st = (link_st == ST_WAIT_LINK_DETECT_LOCKED) ||
                       (link_st == ST_COMMA_HUNTING && change_freq_st);
    assign reset_st  = (link_st == ST_INIT && !change_freq_st) ||
                       (link_st == ST_LINK_LOST_ERR);

    // Highest common speed, later bits win
    always_comb begin
        top_speed = SPD_X1;
        top_valid = 1'b0;
        for (int i = 0; i < 12; i++) begin
            if (speed_select[i]) begin
                top_speed = link_speed_t'(i);
                top_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            speed_reg <= SPD_X1;
            ddr_reg   <= 1'b0;
        end else if (reset_st) begin
            speed_reg <= SPD_X1;
            ddr_reg   <= 1'b0;
        end else if (update_st) begin
            if (top_valid) begin
                speed_reg <= top_speed;
            end
            ddr_reg <= speed_select[DDR_BIT];
        end
    end

    // Status is only valid once the link has moved past speed training
    assign status_en  = (link_st >= ST_WAIT_LINK_ADVERTISE_LOCKED && link_st != ST_LINK_LOST_ERR) ||
                        (link_st == ST_COMMA_HUNTING && change_freq_st);
    assign link_speed = status_en ? speed_reg : SPD_X1;
    assign lvds_ddr   = status_en ? ddr_reg : 1'b0;

endmodule

`default_nettype wire

// File: logic/ltpi_tx_pkg.sv
// Shared LTPI transmit types and constants, imported by every module of the transmit manager
`default_nettype none

package ltpi_tx_pkg;

    // Training states, order matters for "advertise or later" checks
    typedef enum logic [3:0] {
        ST_INIT,
        ST_COMMA_HUNTING,
        ST_WAIT_LINK_DETECT_LOCKED,
        ST_WAIT_LINK_SPEED_LOCKED,
        ST_LINK_SPEED_CHANGE,
        ST_WAIT_LINK_ADVERTISE_LOCKED,
        ST_WAIT_IN_ADVERTISE,
        ST_CONFIGURATION_OR_ACCEPT,
        ST_OPERATIONAL,
        ST_OPERATIONAL_RESET,
        ST_LINK_LOST_ERR
    } link_st_t;

    typedef enum logic [2:0] {
        FRM_IDLE,
        FRM_DETECT,
        FRM_SPEED,
        FRM_ADVERTISE,
        FRM_CONFIGURE,
        FRM_OPERATIONAL
    } frame_kind_t;

    // Value equals the capability bit index
    typedef enum logic [3:0] {
        SPD_X1, SPD_X2, SPD_X3, SPD_X4, SPD_X6, SPD_X8,
        SPD_X10, SPD_X12, SPD_X16, SPD_X24, SPD_X32, SPD_X40
    } link_speed_t;

    // Byte 0 comma, byte 1 subtype, bytes 2..15 data
    typedef logic [15:0][7:0] frame_t;
    typedef logic [7:0][7:0]  capab_bytes_t;
    typedef logic [3:0]       frm_offset_t;
    typedef logic [15:0]      speed_capab_t;

    // --------------------
    // Symbols and subtypes
    localparam logic [7:0] K28_5              = 8'hBC;
    localparam logic [7:0] K28_6              = 8'hDC;
    localparam logic [7:0] SUB_DETECT         = 8'h00;
    localparam logic [7:0] SUB_SPEED          = 8'h01;
    localparam logic [7:0] SUB_ADVERTISE      = 8'h00;
    localparam logic [7:0] SUB_CONFIGURE      = 8'h01;
    localparam logic [7:0] LTPI_VERSION       = 8'h01;
    localparam logic [7:0] CAPAB_TYPE_DEFAULT = 8'h00;

    // --------------------
    // Frame pacing and thresholds
    localparam frm_offset_t LAST_OFFSET        = 4'd15;
    localparam logic [15:0] DETECT_FRM_TARGET  = 16'd255;
    localparam logic [7:0]  SPEED_FRM_TARGET   = 8'd7;
    localparam logic [7:0]  CFG_TIMEOUT_FRAMES = 8'd32;

    // DDR flag position in the speed capability mask
    localparam int DDR_BIT = 15;

endpackage

`default_nettype wire

// File: sources.f
logic/ltpi_tx_pkg.sv
logic/ltpi_frame_builder.sv
logic/ltpi_frame_counters.sv
logic/ltpi_speed_negotiator.sv
logic/ltpi_mgmt_tx.sv
dv/ltpi_mgmt_tx_tb.sv
